// ==== all.f ====
+incdir+include
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/button_sync.sv
hdl/mode_ctrl.sv
hdl/hms_counter.sv
hdl/alarm_unit.sv
hdl/seg_display.sv
hdl/digital_clock.sv
tests/digital_clock_chk.sv
tests/tb_digital_clock.sv

// ==== hdl/alarm_unit.sv ====
// alarm compare, o_alarm latches on a match while enabled
// clearing the enable drops the output on the next cycle

`timescale 1ns/100ps
`default_nettype none

module alarm_unit (
	input  logic            clk,
	input  logic            rst_n,
	input  clock_pkg::hms_t i_sec,
	input  clock_pkg::hms_t i_min,
	input  clock_pkg::hms_t i_hou,
	input  clock_pkg::hms_t i_al_sec,
	input  clock_pkg::hms_t i_al_min,
	input  clock_pkg::hms_t i_al_hou,
	input  logic            i_alarm_en,
	output logic            o_alarm
);

	import clock_pkg::*;

	logic match;

	assign match = (i_sec == i_al_sec) && (i_min == i_al_min) && (i_hou == i_al_hou);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (match | o_alarm);	// held until disabled
		end
	end

endmodule

`default_nettype wire

// ==== hdl/button_sync.sv ====
// push button synchronizer and debouncer
// gives one o_press pulse per press, sampled on i_sample

`timescale 1ns/100ps
`default_nettype none

module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_btn,		// raw button, high when pressed
	input  logic i_sample,	// debounce sample enable
	output logic o_press
);

	logic       sync1;
	logic       sync2;
	logic [1:0] hist;	// [0] newest sample
	logic       accept;

	// two-flop synchronizer on the raw pin
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= 1'b0;
			sync2 <= 1'b0;
		end else begin
			sync1 <= i_btn;
			sync2 <= sync1;
		end
	end

	// low, high, high over three samples is a new press
	assign accept = i_sample & sync2 & hist[0] & ~hist[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hist    <= 2'b00;
			o_press <= 1'b0;
		end else begin
			if (i_sample) begin
				hist <= {hist[0], sync2};
			end
			o_press <= accept;	// held button never repeats the pattern
		end
	end

endmodule

`default_nettype wire

// ==== hdl/clock_pkg.sv ====
// shared types of the digital clock
// modules take these by a wildcard import in their body

`default_nettype none

package clock_pkg;

	// operating mode, advanced by the mode button
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	// field under edit, advanced by the position button
	typedef enum logic [1:0] {
		FLD_SEC = 2'd0,
		FLD_MIN = 2'd1,
		FLD_HOU = 2'd2
	} field_t;

	// one hours, minutes or seconds value, 0 to 59
	typedef logic [5:0] hms_t;

	// single decimal digit
	typedef logic [3:0] bcd_t;

	// segments {a, b, c, d, e, f, g}, a lit segment is 1
	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

// ==== hdl/digital_clock.sv ====
// top level of the six-digit 24-hour clock with alarm
// divisors are parameters so a testbench can run fast

`timescale 1ns/100ps
`default_nettype none

`include "clock_defines.svh"

module digital_clock #(
	parameter int SEC_DIV  = `CLK_SEC_DIV,
	parameter int SCAN_DIV = `CLK_SCAN_DIV,
	parameter int DEB_DIV  = `CLK_DEB_DIV
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_btn_mode,		// next mode
	input  logic            i_btn_pos,		// next field
	input  logic            i_btn_inc,		// add one to field
	input  logic            i_btn_alarm,	// alarm enable toggle
	output clock_pkg::seg_t o_seg,
	output logic            o_seg_dp,
	output logic [5:0]      o_seg_enb,
	output logic            o_alarm
);

	import clock_pkg::*;

	logic       sec_tick;
	logic       scan_tick;
	logic       deb_tick;
	logic       press_mode;
	logic       press_pos;
	logic       press_inc;
	logic       press_alarm;
	mode_t      mode;
	field_t     field;
	logic       alarm_en;
	logic       time_tick;
	logic [2:0] time_inc;
	logic [2:0] alarm_inc;
	hms_t       sec;
	hms_t       min;
	hms_t       hou;
	hms_t       al_sec;
	hms_t       al_min;
	hms_t       al_hou;

	// ------------------------------------------------------------------------
	// enables and buttons
	// ------------------------------------------------------------------------
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(DEB_DIV))  u_deb_tick  (.clk(clk), .rst_n(rst_n), .o_tick(deb_tick));

	button_sync u_btn_mode (
		.clk(clk), .rst_n(rst_n), .i_btn(i_btn_mode), .i_sample(deb_tick), .o_press(press_mode)
	);
	button_sync u_btn_pos (
		.clk(clk), .rst_n(rst_n), .i_btn(i_btn_pos), .i_sample(deb_tick), .o_press(press_pos)
	);
	button_sync u_btn_inc (
		.clk(clk), .rst_n(rst_n), .i_btn(i_btn_inc), .i_sample(deb_tick), .o_press(press_inc)
	);
	button_sync u_btn_alarm (
		.clk(clk), .rst_n(rst_n), .i_btn(i_btn_alarm), .i_sample(deb_tick),
		.o_press(press_alarm)
	);

	// ------------------------------------------------------------------------
	// control, counters and alarm
	// ------------------------------------------------------------------------
	mode_ctrl u_mode_ctrl (
		.clk(clk), .rst_n(rst_n),
		.i_press_mode(press_mode), .i_press_pos(press_pos),
		.i_press_inc(press_inc), .i_press_alarm(press_alarm),
		.i_sec_tick(sec_tick),
		.o_mode(mode), .o_field(field), .o_alarm_en(alarm_en),
		.o_time_tick(time_tick), .o_time_inc(time_inc), .o_alarm_inc(alarm_inc)
	);

	hms_counter u_time_cnt (
		.clk(clk), .rst_n(rst_n), .i_tick(time_tick), .i_inc(time_inc),
		.o_sec(sec), .o_min(min), .o_hou(hou)
	);

	hms_counter u_alarm_cnt (	// set by buttons only
		.clk(clk), .rst_n(rst_n), .i_tick(1'b0), .i_inc(alarm_inc),
		.o_sec(al_sec), .o_min(al_min), .o_hou(al_hou)
	);

	alarm_unit u_alarm (
		.clk(clk), .rst_n(rst_n),
		.i_sec(sec), .i_min(min), .i_hou(hou),
		.i_al_sec(al_sec), .i_al_min(al_min), .i_al_hou(al_hou),
		.i_alarm_en(alarm_en), .o_alarm(o_alarm)
	);

	seg_display u_disp (
		.clk(clk), .rst_n(rst_n), .i_mode(mode), .i_field(field),
		.i_sec(sec), .i_min(min), .i_hou(hou),
		.i_al_sec(al_sec), .i_al_min(al_min), .i_al_hou(al_hou),
		.i_scan(scan_tick),
		.o_seg(o_seg), .o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb)
	);

endmodule

`default_nettype wire

// ==== hdl/hms_counter.sv ====
// hours, minutes and seconds counters with carry
// i_tick counts with carry, i_inc bumps a single field without carry

`timescale 1ns/100ps
`default_nettype none

`include "clock_defines.svh"

module hms_counter (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_tick,
	input  logic [2:0]      i_inc,	// {hou, min, sec}
	output clock_pkg::hms_t o_sec,
	output clock_pkg::hms_t o_min,
	output clock_pkg::hms_t o_hou
);

	import clock_pkg::*;

	localparam hms_t SEC_MAX = hms_t'(`CLK_SEC_MAX);
	localparam hms_t MIN_MAX = hms_t'(`CLK_MIN_MAX);
	localparam hms_t HOU_MAX = hms_t'(`CLK_HOU_MAX);

	logic sec_wrap;
	logic min_wrap;
	logic sec_step;
	logic min_step;
	logic hou_step;

	function automatic hms_t next_val(hms_t v, hms_t max);
		return (v >= max) ? hms_t'(0) : hms_t'(v + 1'b1);
	endfunction

	assign sec_wrap = (o_sec == SEC_MAX);
	assign min_wrap = (o_min == MIN_MAX);

	// carry ripples through on the same edge
	assign sec_step = i_tick | i_inc[0];
	assign min_step = (i_tick & sec_wrap) | i_inc[1];
	assign hou_step = (i_tick & sec_wrap & min_wrap) | i_inc[2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hou <= '0;
		end else begin
			if (sec_step) begin
				o_sec <= next_val(o_sec, SEC_MAX);
			end
			if (min_step) begin
				o_min <= next_val(o_min, MIN_MAX);
			end
			if (hou_step) begin
				o_hou <= next_val(o_hou, HOU_MAX);	// 23 back to 0
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mode_ctrl.sv ====
// mode, field and alarm enable registers of the clock
// routes the increment button and the second tick to the counters

`timescale 1ns/100ps
`default_nettype none

module mode_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_press_mode,
	input  logic              i_press_pos,
	input  logic              i_press_inc,
	input  logic              i_press_alarm,
	input  logic              i_sec_tick,
	output clock_pkg::mode_t  o_mode,
	output clock_pkg::field_t o_field,
	output logic              o_alarm_en,
	output logic              o_time_tick,
	output logic [2:0]        o_time_inc,	// {hou, min, sec}
	output logic [2:0]        o_alarm_inc	// {hou, min, sec}
);

	import clock_pkg::*;

	// one-hot increment for the selected field
	function automatic logic [2:0] field_sel(field_t f);
		case (f)
			FLD_SEC: return 3'b001;
			FLD_MIN: return 3'b010;
			FLD_HOU: return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_field    <= FLD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press_mode) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (i_press_pos) begin
				case (o_field)
					FLD_SEC: o_field <= FLD_MIN;
					FLD_MIN: o_field <= FLD_HOU;
					default: o_field <= FLD_SEC;
				endcase
			end
			if (i_press_alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// ------------------------------------------------------------------------
	// increment and tick routing, same cycle as the press
	// ------------------------------------------------------------------------
	assign o_time_tick = i_sec_tick && (o_mode != MODE_SETUP);	// time frozen while set

	assign o_time_inc  = (i_press_inc && o_mode == MODE_SETUP) ? field_sel(o_field) : 3'b000;
	assign o_alarm_inc = (i_press_inc && o_mode == MODE_ALARM) ? field_sel(o_field) : 3'b000;

endmodule

`default_nettype wire

// ==== hdl/seg_display.sv ====
// six-digit multiplexed seven-segment driver
// shows the alarm time in alarm mode, the time otherwise
// decimal point marks the field being edited

`timescale 1ns/100ps
`default_nettype none

`include "clock_defines.svh"

module seg_display (
	input  logic              clk,
	input  logic              rst_n,
	input  clock_pkg::mode_t  i_mode,
	input  clock_pkg::field_t i_field,
	input  clock_pkg::hms_t   i_sec,
	input  clock_pkg::hms_t   i_min,
	input  clock_pkg::hms_t   i_hou,
	input  clock_pkg::hms_t   i_al_sec,
	input  clock_pkg::hms_t   i_al_min,
	input  clock_pkg::hms_t   i_al_hou,
	input  logic              i_scan,		// scan step enable
	output clock_pkg::seg_t   o_seg,
	output logic              o_seg_dp,
	output logic [5:0]        o_seg_enb		// active low, one digit at a time
);

	import clock_pkg::*;

	localparam int   ND       = `CLK_NUM_DIGITS;
	localparam hms_t SEC_MAX  = hms_t'(`CLK_SEC_MAX);
	localparam hms_t MIN_MAX  = hms_t'(`CLK_MIN_MAX);
	localparam hms_t HOU_MAX  = hms_t'(`CLK_HOU_MAX);
	localparam bcd_t BLANK    = 4'hf;
	localparam seg_t SEG_ZERO = 7'b111_1110;

	logic [2:0] scan_idx;
	logic [2:0] dp_idx;
	hms_t       show_sec;
	hms_t       show_min;
	hms_t       show_hou;
	hms_t       fld_val;
	hms_t       fld_max;
	bcd_t       digit;
	logic       dp_on;

	function automatic seg_t bcd_to_seg(bcd_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// blank
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// scan index, 0 is the rightmost digit
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan) begin
			if (scan_idx == 3'(ND - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// source select, split and decode
	// ------------------------------------------------------------------------
	assign show_sec = (i_mode == MODE_ALARM) ? i_al_sec : i_sec;
	assign show_min = (i_mode == MODE_ALARM) ? i_al_min : i_min;
	assign show_hou = (i_mode == MODE_ALARM) ? i_al_hou : i_hou;

	always_comb begin
		case (scan_idx[2:1])	// two digits per field
			2'd0: begin
				fld_val = show_sec;
				fld_max = SEC_MAX;
			end
			2'd1: begin
				fld_val = show_min;
				fld_max = MIN_MAX;
			end
			default: begin
				fld_val = show_hou;
				fld_max = HOU_MAX;
			end
		endcase

		// odd index is the tens digit
		if (fld_val > fld_max) begin
			digit = BLANK;	// out of range shows nothing
		end else if (scan_idx[0]) begin
			digit = bcd_t'(fld_val / 10);
		end else begin
			digit = bcd_t'(fld_val % 10);
		end
	end

	// setup marks the ones digit, alarm the tens digit of the field
	assign dp_idx = {i_field, i_mode == MODE_ALARM};
	assign dp_on  = (i_mode != MODE_CLOCK) && (scan_idx == dp_idx);

	// registered pin drivers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= SEG_ZERO;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= 6'b111110;
		end else begin
			o_seg     <= bcd_to_seg(digit);
			o_seg_dp  <= dp_on;
			o_seg_enb <= ~(6'b000001 << scan_idx);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tick_gen.sv ====
// prescaler giving a one-cycle enable every DIV clk cycles
// replaces the derived clocks, everything stays on clk

`timescale 1ns/100ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			if (cnt == CW'(DIV - 1)) begin
				cnt    <= '0;
				o_tick <= 1'b1;	// one pulse per wrap
			end else begin
				cnt    <= cnt + 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== include/clock_defines.svh ====
// default divisors and field limits for the six-digit clock
// include where a divisor, a limit or the digit count is needed

`ifndef CLOCK_DEFINES_SVH
`define CLOCK_DEFINES_SVH

// ------------------------------------------------------------------------
// prescaler divisors, in clk cycles
// ------------------------------------------------------------------------
`define CLK_SEC_DIV		50000000	// one second at 50 MHz
`define CLK_SCAN_DIV	5000		// per digit scan step
`define CLK_DEB_DIV		500000		// button sample period

// ------------------------------------------------------------------------
// field limits, last value before wrap
// ------------------------------------------------------------------------
`define CLK_SEC_MAX		59
`define CLK_MIN_MAX		59
`define CLK_HOU_MAX		23

// number of multiplexed digits on the board
`define CLK_NUM_DIGITS	6

`endif

// ==== tests/digital_clock_chk.sv ====
// concurrent checks on the clock top level, bound into every digital_clock
// covers the digit enables, the decimal point and the alarm output

`timescale 1ns/100ps
`default_nettype none

module digital_clock_chk (
	input logic             clk,
	input logic             rst_n,
	input clock_pkg::mode_t i_mode,
	input logic             i_alarm_en,
	input logic             i_seg_dp,
	input logic [5:0]       i_seg_enb,
	input logic             i_alarm
);

	import clock_pkg::*;

	int fails = 0;	// read by the testbench at the end

	// exactly one digit driven at a time
	enb_one_low: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_seg_enb))
		else begin
			$error("digit enables %b do not select exactly one digit", i_seg_enb);
			fails++;
		end

	// point register follows the mode one cycle late
	dp_off_in_clock: assert property (@(posedge clk) disable iff (!rst_n)
		($past(i_mode) == MODE_CLOCK) |-> !i_seg_dp)
		else begin
			$error("decimal point lit in clock mode");
			fails++;
		end

	alarm_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(i_alarm_en) |-> !i_alarm)	// output register lags enable
		else begin
			$error("alarm output high with the alarm disabled");
			fails++;
		end

endmodule

bind digital_clock digital_clock_chk chk_i (
	.clk(clk), .rst_n(rst_n), .i_mode(mode), .i_alarm_en(alarm_en),
	.i_seg_dp(o_seg_dp), .i_seg_enb(o_seg_enb), .i_alarm(o_alarm)
);

`default_nettype wire

// ==== tests/tb_digital_clock.sv ====
// directed testbench for the six-digit clock run with short divisors
// reads the multiplexed display pins back into time values and checks them

`timescale 1ns/100ps
`default_nettype none

module tb_digital_clock;

	import clock_pkg::*;

	localparam int SEC_DIV   = 40;
	localparam int SCAN_DIV  = 2;
	localparam int DEB_DIV   = 4;
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       btn_mode, btn_pos, btn_inc, btn_alarm;
	seg_t       seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	int          errors;
	logic        timed_out;
	string       test_name;
	logic [16:0] lfsr;
	hms_t        disp_sec, disp_min, disp_hou;	// last stable reading
	logic [5:0]  disp_dp;						// bit set where the point is lit

	always #50 clk = ~clk;

	digital_clock #(.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV), .DEB_DIV(DEB_DIV)) digital_clock_i (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(btn_mode), .i_btn_pos(btn_pos), .i_btn_inc(btn_inc),
		.i_btn_alarm(btn_alarm),
		.o_seg(seg), .o_seg_dp(seg_dp), .o_seg_enb(seg_enb), .o_alarm(alarm)
	);

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [16:0] lfsr_next(logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};	// x^17 + x^14 + 1
	endfunction

	task automatic random_bits(input int nbits, output int val);
		val = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | lfsr[0];
		end
	endtask

	// segments a to g back to a digit or -1 for an unknown pattern
	function automatic int seg_to_digit(seg_t s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return -1;
		endcase
	endfunction

	task automatic drive_button(input int which, input logic level);
		case (which)
			BTN_MODE: btn_mode  = level;
			BTN_POS:  btn_pos   = level;
			BTN_INC:  btn_inc   = level;
			default:  btn_alarm = level;
		endcase
	endtask

	task automatic press_button(input int which);
		@(negedge clk);
		drive_button(which, 1'b1);
		repeat (12) @(negedge clk);
		drive_button(which, 1'b0);
		repeat (12) @(negedge clk);
	endtask

	task automatic compare_hms(input string item, input hms_t exp, input hms_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s, %s: expected %0d, actual %0d", test_name, item, exp, act);
		end
	endtask

	task automatic compare_bit(input string item, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s, %s: expected %b, actual %b", test_name, item, exp, act);
		end
	endtask

	task automatic compare_mask(input string item, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s, %s: expected %b, actual %b", test_name, item, exp, act);
		end
	endtask

	// one pass over all six digits sampled between clock edges
	task automatic read_scan(output hms_t sec, output hms_t min, output hms_t hou,
			output logic [5:0] dp);
		int         dig [6];
		logic [5:0] seen;
		int         idx;
		int         val;
		int         cycles;
		seen   = '0;
		dp     = '0;
		cycles = 0;
		foreach (dig[i]) dig[i] = 0;
		while (seen != 6'b111111 && cycles < 40) begin
			@(negedge clk);
			cycles++;
			idx = -1;
			for (int i = 0; i < 6; i++) begin
				if (seg_enb == ~(6'b000001 << i)) idx = i;
			end
			if (idx < 0) begin
				errors++;
				$display("Error in %s: digit enables %b select no single digit",
					test_name, seg_enb);
			end else begin
				val = seg_to_digit(seg);
				if (val < 0) begin
					errors++;
					$display("Error in %s: unknown segment pattern %b", test_name, seg);
				end else begin
					dig[idx] = val;
				end
				seen[idx] = 1'b1;
				dp[idx]   = seg_dp;
			end
		end
		if (seen != 6'b111111) begin
			timed_out = 1'b1;
			errors++;
			$display("Error in %s: scan did not reach all six digits in 40 cycles", test_name);
		end
		sec = hms_t'(dig[1] * 10 + dig[0]);
		min = hms_t'(dig[3] * 10 + dig[2]);
		hou = hms_t'(dig[5] * 10 + dig[4]);
	endtask

	// repeat scans until two in a row agree
	task automatic read_display();
		hms_t       s0, m0, h0, s1, m1, h1;
		logic [5:0] d0, d1;
		int         tries;
		logic       stable;
		stable = 1'b0;
		tries  = 0;
		read_scan(s0, m0, h0, d0);
		s1 = s0;
		m1 = m0;
		h1 = h0;
		d1 = d0;
		while (!stable && !timed_out && tries < 8) begin
			read_scan(s1, m1, h1, d1);
			tries++;
			if (s1 == s0 && m1 == m0 && h1 == h0 && d1 == d0) begin
				stable = 1'b1;
			end else begin
				s0 = s1;
				m0 = m1;
				h0 = h1;
				d0 = d1;
			end
		end
		if (!stable && !timed_out) begin
			timed_out = 1'b1;
			errors++;
			$display("Error in %s: display never settled over 8 scans", test_name);
		end
		disp_sec = s1;
		disp_min = m1;
		disp_hou = h1;
		disp_dp  = d1;
	endtask

	task automatic wait_change(input hms_t s, input hms_t m, input hms_t h);
		int reads;
		reads = 0;
		read_display();
		while (!timed_out && reads < 6 && disp_sec == s && disp_min == m && disp_hou == h) begin
			read_display();
			reads++;
		end
		if (!timed_out && disp_sec == s && disp_min == m && disp_hou == h) begin
			timed_out = 1'b1;
			errors++;
			$display("Error in %s: displayed time did not change within 6 readings", test_name);
		end
	endtask

	task automatic wait_alarm(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (alarm !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (alarm !== level) begin
			timed_out = 1'b1;
			errors++;
			$display("Error in %s: alarm output did not go to %b within %0d cycles",
				test_name, level, limit);
		end
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		test_name = "reset";
		read_display();
		if (timed_out) return;
		compare_hms("seconds", 0, disp_sec);
		compare_hms("minutes", 0, disp_min);
		compare_hms("hours", 0, disp_hou);
		compare_mask("decimal points", 6'b000000, disp_dp);
		compare_bit("alarm", 1'b0, alarm);
	endtask

	task automatic test_counting();
		hms_t ps, pm, ph, es, em, eh;
		logic carried;
		int   steps;
		test_name = "counting";
		carried   = 1'b0;
		steps     = 0;
		read_display();
		ps = disp_sec;
		pm = disp_min;
		ph = disp_hou;
		while (!carried && !timed_out && steps < 70) begin
			wait_change(ps, pm, ph);
			if (timed_out) return;
			es = (ps == 59) ? hms_t'(0) : hms_t'(ps + 1);
			em = (ps == 59) ? ((pm == 59) ? hms_t'(0) : hms_t'(pm + 1)) : pm;
			eh = (ps == 59 && pm == 59) ? ((ph == 23) ? hms_t'(0) : hms_t'(ph + 1)) : ph;
			compare_hms("seconds", es, disp_sec);
			compare_hms("minutes", em, disp_min);
			compare_hms("hours", eh, disp_hou);
			carried = (ps == 59);
			ps = disp_sec;
			pm = disp_min;
			ph = disp_hou;
			steps++;
		end
		compare_bit("minute carry seen", 1'b1, carried);
	endtask

	task automatic test_setup();
		hms_t bs, bm, bh;
		int   n;
		test_name = "setup";
		press_button(BTN_MODE);
		press_button(BTN_POS);	// seconds to minutes
		read_display();
		if (timed_out) return;
		bs = disp_sec;
		bm = disp_min;
		bh = disp_hou;
		random_bits(3, n);
		n = n % 7 + 1;
		repeat (n) press_button(BTN_INC);
		read_display();
		if (timed_out) return;
		compare_hms("minutes", hms_t'((bm + n) % 60), disp_min);
		compare_hms("seconds", bs, disp_sec);
		compare_hms("hours", bh, disp_hou);
		compare_mask("decimal points", 6'b000100, disp_dp);
		repeat (3 * SEC_DIV) @(negedge clk);	// idle over several second ticks
		read_display();
		if (timed_out) return;
		compare_hms("frozen seconds", bs, disp_sec);
	endtask

	task automatic test_hour_wrap();
		hms_t bs, bm, bh;
		test_name = "hour wrap";
		press_button(BTN_POS);
		read_display();
		if (timed_out) return;
		bs = disp_sec;
		bm = disp_min;
		bh = disp_hou;
		repeat (23) press_button(BTN_INC);
		read_display();
		if (timed_out) return;
		compare_hms("hours before wrap", hms_t'((bh + 23) % 24), disp_hou);
		press_button(BTN_INC);	// last press wraps the hour
		read_display();
		if (timed_out) return;
		compare_hms("hours", bh, disp_hou);
		compare_hms("minutes", bm, disp_min);
		compare_hms("seconds", bs, disp_sec);
		compare_mask("decimal points", 6'b010000, disp_dp);
	endtask

	task automatic test_alarm();
		int am;
		test_name = "alarm";
		am = (disp_min + 1) % 60;	// time minutes frozen since setup
		press_button(BTN_MODE);
		read_display();
		if (timed_out) return;
		compare_hms("alarm seconds", 0, disp_sec);
		compare_hms("alarm minutes", 0, disp_min);
		compare_hms("alarm hours", 0, disp_hou);
		compare_mask("hour point", 6'b100000, disp_dp);
		press_button(BTN_POS);
		read_display();
		compare_mask("second point", 6'b000010, disp_dp);
		press_button(BTN_POS);
		read_display();
		compare_mask("minute point", 6'b001000, disp_dp);
		repeat (am) press_button(BTN_INC);
		read_display();
		if (timed_out) return;
		compare_hms("set alarm minutes", hms_t'(am), disp_min);
		press_button(BTN_ALARM);
		press_button(BTN_MODE);	// back to clock mode
		compare_bit("alarm before match", 1'b0, alarm);
		wait_alarm(1'b1, 120 * SEC_DIV);
		if (timed_out) return;
		read_display();
		compare_hms("minutes at alarm", hms_t'(am), disp_min);
		compare_bit("alarm held", 1'b1, alarm);
		press_button(BTN_ALARM);
		wait_alarm(1'b0, 50);
	endtask

	initial begin
		rst_n     = 1'b0;
		btn_mode  = 1'b0;
		btn_pos   = 1'b0;
		btn_inc   = 1'b0;
		btn_alarm = 1'b0;
		errors    = 0;
		timed_out = 1'b0;
		test_name = "init";
		lfsr      = 17'd95993;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		test_reset();
		if (!timed_out) test_counting();
		if (!timed_out) test_setup();
		if (!timed_out) test_hour_wrap();
		if (!timed_out) test_alarm();

		$display("failed checks: %0d, failed assertions: %0d",
			errors, digital_clock_i.chk_i.fails);
		if (errors == 0 && digital_clock_i.chk_i.fails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
